// ==== build.f ====
logic/gpu_cmd_pkg.sv
logic/cmd_fifo.sv
logic/reg_file.sv
logic/mem_fill.sv
logic/mem_arbiter.sv
logic/gpu_cmd_top.sv
bench/gpu_cmd_assertions.sv
bench/gpu_cmd_tb.sv

// ==== bench/gpu_cmd_tb.sv ====
`timescale 1ns/1ps

module gpu_cmd_tb;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int NUM_BATCHES    = 40;

    logic                   clk_core;
    logic                   rst_n_core;
    logic                   cmd_valid;
    gpu_cmd_pkg::cmd_t      cmd;
    logic                   cmd_credit;
    logic                   rsp_valid;
    gpu_cmd_pkg::reg_data_t rsp_data;
    logic                   frame_tick;
    logic                   mem_valid;
    gpu_cmd_pkg::mem_wr_t   mem_wr;
    logic                   mem_ack;

    integer seed;
    int     depth;
    int     credits;

    // Memory responder state
    bit          req_open;
    int unsigned ack_delay;

    // Reference model
    gpu_cmd_pkg::mem_addr_t               m_base;
    gpu_cmd_pkg::mem_data_t               m_value;
    logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] m_count;
    gpu_cmd_pkg::mem_addr_t               m_ts_addr;
    gpu_cmd_pkg::frame_count_t            m_frames;
    gpu_cmd_pkg::reg_data_t               exp_rsp [$];
    gpu_cmd_pkg::mem_wr_t                 exp_mem [$];

    gpu_cmd_top i_dut (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .frame_tick (frame_tick),
        .mem_valid  (mem_valid),
        .mem_wr     (mem_wr),
        .mem_ack    (mem_ack)
    );

    initial clk_core = 1'b0;
    always #20 clk_core = ~clk_core;

    // ============================================================
    // Failure reporting and compare tasks
    // ============================================================

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input gpu_cmd_pkg::reg_data_t actual,
                             input gpu_cmd_pkg::reg_data_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: rsp_data actual %h expected %h",
                     $time, actual, expected);
            $display("Regression failed");
            $fatal(1, "read response mismatch");
        end
    endtask

    task automatic check_mem(input gpu_cmd_pkg::mem_wr_t actual,
                             input gpu_cmd_pkg::mem_wr_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: mem_wr actual addr %h data %h expected addr %h data %h",
                     $time, actual.addr, actual.wdata, expected.addr, expected.wdata);
            $display("Regression failed");
            $fatal(1, "memory write mismatch");
        end
    endtask

    task automatic check_credits(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("MISMATCH at %0t: %s actual %0d expected %0d",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "credit count mismatch");
        end
    endtask

    // ============================================================
    // Random helpers and reference model
    // ============================================================

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Addresses with a meaning in the register map
    function automatic gpu_cmd_pkg::reg_addr_t mapped_addr(input int unsigned k);
        case (k)
            0:       return gpu_cmd_pkg::REG_FILL_BASE;
            1:       return gpu_cmd_pkg::REG_FILL_VALUE;
            2:       return gpu_cmd_pkg::REG_FILL_COUNT;
            3:       return gpu_cmd_pkg::REG_TS_ADDR;
            default: return gpu_cmd_pkg::REG_FRAME_COUNT;
        endcase
    endfunction

    // Holes in the map from 0x00 to 0x0f and from 0x40 up
    function automatic gpu_cmd_pkg::reg_addr_t unmapped_addr();
        if (rand_below(2) == 0) begin
            return gpu_cmd_pkg::reg_addr_t'(rand_below(16));
        end
        return gpu_cmd_pkg::reg_addr_t'(7'h40 + rand_below(64));
    endfunction

    function automatic gpu_cmd_pkg::cmd_t random_cmd();
        gpu_cmd_pkg::cmd_t c;
        c.rw   = 1'b0;
        c.addr = unmapped_addr();
        c.data = $random(seed);
        case (rand_below(8))
            0: c.addr = gpu_cmd_pkg::REG_FILL_BASE;
            1: c.addr = gpu_cmd_pkg::REG_FILL_VALUE;
            2: begin
                // Junk above the count field and a small count below
                c.addr = gpu_cmd_pkg::REG_FILL_COUNT;
                c.data = (c.data & 32'hfff0_0000) | rand_below(7);
            end
            3: c.addr = gpu_cmd_pkg::REG_TS_ADDR;
            4, 5: begin
                c.rw   = 1'b1;
                c.addr = mapped_addr(rand_below(5));
            end
            6: c.rw = 1'b1;
            default: ;
        endcase
        return c;
    endfunction

    function automatic gpu_cmd_pkg::reg_data_t read_model(input gpu_cmd_pkg::reg_addr_t addr);
        case (addr)
            gpu_cmd_pkg::REG_FILL_BASE:   return gpu_cmd_pkg::reg_data_t'(m_base);
            gpu_cmd_pkg::REG_FILL_VALUE:  return gpu_cmd_pkg::reg_data_t'(m_value);
            gpu_cmd_pkg::REG_FILL_COUNT:  return gpu_cmd_pkg::reg_data_t'(m_count);
            gpu_cmd_pkg::REG_TS_ADDR:     return gpu_cmd_pkg::reg_data_t'(m_ts_addr);
            gpu_cmd_pkg::REG_FRAME_COUNT: return gpu_cmd_pkg::reg_data_t'(m_frames);
            default:                      return '0;
        endcase
    endfunction

    // Commands run in push order, so the model steps at push time
    task automatic model_cmd(input gpu_cmd_pkg::cmd_t c);
        gpu_cmd_pkg::mem_wr_t w;
        int                   i;
        if (c.rw) begin
            exp_rsp.push_back(read_model(c.addr));
        end else begin
            case (c.addr)
                gpu_cmd_pkg::REG_FILL_BASE:
                    m_base = c.data[gpu_cmd_pkg::MEM_ADDR_W-1:0];
                gpu_cmd_pkg::REG_FILL_VALUE:
                    m_value = c.data[gpu_cmd_pkg::MEM_DATA_W-1:0];
                gpu_cmd_pkg::REG_FILL_COUNT: begin
                    m_count = c.data[gpu_cmd_pkg::FILL_COUNT_W-1:0];
                    for (i = 0; i < int'(m_count); i++) begin
                        w.addr  = m_base + gpu_cmd_pkg::mem_addr_t'(i);
                        w.wdata = m_value;
                        exp_mem.push_back(w);
                    end
                end
                gpu_cmd_pkg::REG_TS_ADDR: begin
                    m_ts_addr = c.data[gpu_cmd_pkg::MEM_ADDR_W-1:0];
                    w.addr    = m_ts_addr;
                    w.wdata   = gpu_cmd_pkg::mem_data_t'(m_frames);
                    exp_mem.push_back(w);
                end
                default: ;
            endcase
        end
    endtask

    // ============================================================
    // Drivers
    // ============================================================

    // One push per rising edge and only with a credit in hand
    task automatic send_cmd(input gpu_cmd_pkg::cmd_t c);
        int waited;
        waited = 0;
        @(posedge clk_core);
        while (credits == 0) begin
            cmd_valid <= 1'b0;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_failure("no command credit came back before the timeout");
            end
            @(posedge clk_core);
        end
        cmd_valid <= 1'b1;
        cmd       <= c;
        credits--;
        model_cmd(c);
    endtask

    task automatic idle_cycle();
        @(posedge clk_core);
        cmd_valid <= 1'b0;
    endtask

    // Ticks only while nothing is queued, so timestamps see a settled count
    task automatic pulse_frame_ticks(input int n);
        repeat (n) begin
            @(posedge clk_core);
            frame_tick <= 1'b1;
            m_frames++;
            @(posedge clk_core);
            frame_tick <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_mem.size() != 0 || exp_rsp.size() != 0 || credits != depth ||
               req_open || mem_ack) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_failure("command and memory traffic did not drain before the timeout");
            end
            @(posedge clk_core);
        end
    endtask

    // ============================================================
    // Monitors and memory responder
    // ============================================================

    // Outputs sampled mid cycle
    always @(negedge clk_core) begin
        // Handshake assertions count their failures in the bound checker
        if (i_dut.u_mem_arbiter.i_assertions.violations != 0) begin
            report_failure("a memory port handshake assertion failed");
        end
        if (!rst_n_core) begin
            if (rsp_valid || mem_valid || cmd_credit) begin
                report_failure("an output was active during reset");
            end
        end else begin
            if (cmd_credit) begin
                credits++;
                if (credits > depth) begin
                    report_failure("more credits came back than commands were pushed");
                end
            end
            if (rsp_valid) begin
                if (exp_rsp.size() == 0) begin
                    report_failure("read response with no read outstanding");
                end
                check_rsp(rsp_data, exp_rsp.pop_front());
            end
            // Check a new request once and pick its ack latency
            if (mem_valid && !req_open) begin
                if (exp_mem.size() == 0) begin
                    report_failure("memory write with none expected");
                end
                check_mem(mem_wr, exp_mem.pop_front());
                req_open  = 1'b1;
                ack_delay = rand_below(6);
            end
        end
    end

    // Single-cycle ack after the chosen delay
    always @(posedge clk_core) begin
        if (mem_ack) begin
            mem_ack  <= 1'b0;
            req_open = 1'b0;
        end else if (req_open) begin
            if (ack_delay == 0) begin
                mem_ack <= 1'b1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        gpu_cmd_pkg::cmd_t c;
        int                b;
        int                k;
        int                n;
        seed       = 32'hc39a;
        rst_n_core = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        frame_tick = 1'b0;
        mem_ack    = 1'b0;
        req_open   = 1'b0;
        ack_delay  = 0;
        m_base     = '0;
        m_value    = '0;
        m_count    = '0;
        m_ts_addr  = '0;
        m_frames   = '0;
        depth      = i_dut.FIFO_DEPTH;
        credits    = depth;

        repeat (16) @(posedge clk_core);
        rst_n_core <= 1'b1;

        // Quiet after reset
        repeat (4) begin
            @(negedge clk_core);
            if (rsp_valid || mem_valid || cmd_credit) begin
                report_failure("an output went active after reset with no traffic");
            end
        end

        // Full burst on the initial credits with a long fill first so the rest queue up
        c.rw   = 1'b0;
        c.addr = gpu_cmd_pkg::REG_FILL_COUNT;
        c.data = gpu_cmd_pkg::reg_data_t'(depth);
        send_cmd(c);
        for (k = 1; k < depth; k++) begin
            c.rw   = 1'b1;
            c.addr = mapped_addr(rand_below(5));
            c.data = $random(seed);
            send_cmd(c);
        end
        @(negedge clk_core);
        // Only the fill command has been popped so far
        check_credits("credit counter", credits, 1);
        wait_drained();

        // Random batches with ticks in between
        for (b = 0; b < NUM_BATCHES; b++) begin
            pulse_frame_ticks(rand_below(4));
            n = 1 + rand_below(2 * depth);
            for (k = 0; k < n; k++) begin
                send_cmd(random_cmd());
                if (rand_below(4) == 0) begin
                    idle_cycle();
                end
            end
            wait_drained();
        end

        // Quiet window where a stray credit, response or write would show
        repeat (4) idle_cycle();

        if (i_dut.u_mem_arbiter.i_assertions.violations == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "memory port assertions failed");
        end
    end

endmodule

// ==== bench/gpu_cmd_assertions.sv ====
`timescale 1ns/1ps

module gpu_cmd_assertions (
    input logic                 clk_core,
    input logic                 rst_n_core,
    input logic                 mem_valid,
    input logic                 mem_ack,
    input gpu_cmd_pkg::mem_wr_t mem_wr,
    input logic                 ts_req,
    input logic                 fill_req,
    input logic                 ts_done,
    input logic                 fill_done
);

    // Failed checks so far, polled by the testbench
    int unsigned violations = 0;

    // ============================================================
    // Memory port handshake
    // ============================================================

    // Request held steady until the ack
    a_req_stable: assert property (@(posedge clk_core) disable iff (!rst_n_core)
        (mem_valid && !mem_ack) |=> (mem_valid && $stable(mem_wr)))
    else begin
        violations++;
        $error("mem_wr changed or mem_valid dropped before mem_ack");
    end

    // Completion only while its requester still holds the request
    a_done_has_req: assert property (@(posedge clk_core) disable iff (!rst_n_core)
        !((ts_done && !ts_req) || (fill_done && !fill_req)))
    else begin
        violations++;
        $error("done pulse without a matching request");
    end

    // Port quiet while reset is held
    a_idle_in_reset: assert property (@(posedge clk_core) !rst_n_core |=> !mem_valid)
    else begin
        violations++;
        $error("mem_valid high during reset");
    end

endmodule

bind mem_arbiter gpu_cmd_assertions i_assertions (
    .clk_core   (clk_core),
    .rst_n_core (rst_n_core),
    .mem_valid  (mem_valid),
    .mem_ack    (mem_ack),
    .mem_wr     (mem_wr),
    .ts_req     (ts_req),
    .fill_req   (fill_req),
    .ts_done    (ts_done),
    .fill_done  (fill_done)
);

// ==== logic/gpu_cmd_top.sv ====
`timescale 1ns/1ps

module gpu_cmd_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   clk_core,
    input  logic                   rst_n_core,
    // Credit-based command intake
    input  logic                   cmd_valid,
    input  gpu_cmd_pkg::cmd_t      cmd,
    output logic                   cmd_credit,
    // Read responses
    output logic                   rsp_valid,
    output gpu_cmd_pkg::reg_data_t rsp_data,
    // Frame start from the display side
    input  logic                   frame_tick,
    // External memory request port
    output logic                   mem_valid,
    output gpu_cmd_pkg::mem_wr_t   mem_wr,
    input  logic                   mem_ack
);

    // ============================================================
    // Internal wiring
    // ============================================================

    // FIFO to register file
    gpu_cmd_pkg::cmd_t                    head_cmd;
    logic                                 not_empty;
    logic                                 pop;

    // Register file to fill engine
    logic                                 fill_start;
    gpu_cmd_pkg::mem_addr_t               fill_base;
    gpu_cmd_pkg::mem_data_t               fill_value;
    logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] fill_count;
    logic                                 fill_busy;

    // Arbiter ports
    logic                                 ts_req;
    gpu_cmd_pkg::mem_wr_t                 ts_wr;
    logic                                 ts_done;
    logic                                 fill_req;
    gpu_cmd_pkg::mem_wr_t                 fill_wr;
    logic                                 fill_done;

    // ============================================================
    // Blocks
    // ============================================================

    cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .push       (cmd_valid),
        .push_cmd   (cmd),
        .pop        (pop),
        .head_cmd   (head_cmd),
        .not_empty  (not_empty),
        .cmd_credit (cmd_credit)
    );

    reg_file u_reg_file (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .head_cmd   (head_cmd),
        .not_empty  (not_empty),
        .fill_busy  (fill_busy),
        .frame_tick (frame_tick),
        .ts_done    (ts_done),
        .pop        (pop),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_value (fill_value),
        .fill_count (fill_count),
        .ts_req     (ts_req),
        .ts_wr      (ts_wr)
    );

    mem_fill u_mem_fill (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_value (fill_value),
        .fill_count (fill_count),
        .fill_done  (fill_done),
        .fill_busy  (fill_busy),
        .fill_req   (fill_req),
        .fill_wr    (fill_wr)
    );

    // Port 0 timestamp, port 1 fill
    mem_arbiter u_mem_arbiter (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .ts_req     (ts_req),
        .ts_wr      (ts_wr),
        .fill_req   (fill_req),
        .fill_wr    (fill_wr),
        .mem_ack    (mem_ack),
        .ts_done    (ts_done),
        .fill_done  (fill_done),
        .mem_valid  (mem_valid),
        .mem_wr     (mem_wr)
    );

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk_core,
    input  logic                 rst_n_core,
    input  logic                 ts_req,
    input  gpu_cmd_pkg::mem_wr_t ts_wr,
    input  logic                 fill_req,
    input  gpu_cmd_pkg::mem_wr_t fill_wr,
    input  logic                 mem_ack,
    output logic                 ts_done,
    output logic                 fill_done,
    output logic                 mem_valid,
    output gpu_cmd_pkg::mem_wr_t mem_wr
);

    typedef enum logic [1:0] {
        IDLE,
        SERVE_TS,
        SERVE_FILL
    } arb_state_t;

    arb_state_t state;

    // ============================================================
    // Grant
    // ============================================================

    // Port 0 is the timestamp, always wins
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (ts_req) begin
                        state <= SERVE_TS;
                    end else if (fill_req) begin
                        state <= SERVE_FILL;
                    end
                end
                // Grant holds until the external ack
                SERVE_TS,
                SERVE_FILL: begin
                    if (mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Winning request captured at grant, steady until ack
    always_ff @(posedge clk_core) begin
        if (state == IDLE) begin
            mem_wr <= ts_req ? ts_wr : fill_wr;
        end
    end

    // ============================================================
    // External port and completions
    // ============================================================

    assign mem_valid = (state != IDLE);

    // Done in the ack cycle so the requester steps before the next grant
    assign ts_done   = (state == SERVE_TS) && mem_ack;
    assign fill_done = (state == SERVE_FILL) && mem_ack;

endmodule

// ==== logic/mem_fill.sv ====
`timescale 1ns/1ps

module mem_fill (
    input  logic                                 clk_core,
    input  logic                                 rst_n_core,
    input  logic                                 fill_start,
    input  gpu_cmd_pkg::mem_addr_t               fill_base,
    input  gpu_cmd_pkg::mem_data_t               fill_value,
    input  logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] fill_count,
    input  logic                                 fill_done,
    output logic                                 fill_busy,
    output logic                                 fill_req,
    output gpu_cmd_pkg::mem_wr_t                 fill_wr
);

    typedef enum logic {
        IDLE,
        WRITE
    } fill_state_t;

    fill_state_t                          state;
    gpu_cmd_pkg::mem_addr_t               cur_addr;
    logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] remaining;
    gpu_cmd_pkg::mem_data_t               value;

    // Request stays up for the whole run, one word per acknowledged transfer
    assign fill_busy     = (state == WRITE);
    assign fill_req      = (state == WRITE);
    assign fill_wr.addr  = cur_addr;
    assign fill_wr.wdata = value;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            state     <= IDLE;
            cur_addr  <= '0;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fill_start && (fill_count != '0)) begin
                        cur_addr  <= fill_base;
                        remaining <= fill_count;
                        state     <= WRITE;
                    end
                end
                WRITE: begin
                    // Advance on each completed word
                    if (fill_done) begin
                        cur_addr  <= cur_addr + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == 1) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Fill pattern, captured once per run
    always_ff @(posedge clk_core) begin
        if (fill_start && (state == IDLE)) begin
            value <= fill_value;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                                 clk_core,
    input  logic                                 rst_n_core,
    input  gpu_cmd_pkg::cmd_t                    head_cmd,
    input  logic                                 not_empty,
    input  logic                                 fill_busy,
    input  logic                                 frame_tick,
    input  logic                                 ts_done,
    output logic                                 pop,
    output logic                                 rsp_valid,
    output gpu_cmd_pkg::reg_data_t               rsp_data,
    output logic                                 fill_start,
    output gpu_cmd_pkg::mem_addr_t               fill_base,
    output gpu_cmd_pkg::mem_data_t               fill_value,
    output logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] fill_count,
    output logic                                 ts_req,
    output gpu_cmd_pkg::mem_wr_t                 ts_wr
);

    logic                                 ts_pending;
    logic                                 wr_en;
    logic [gpu_cmd_pkg::FILL_COUNT_W-1:0] fill_count_q;
    gpu_cmd_pkg::frame_count_t            frame_count;
    gpu_cmd_pkg::reg_data_t               rd_data;

    // ============================================================
    // Command intake
    // ============================================================

    // Hold the queue while a fill or timestamp owns the memory path
    assign pop   = not_empty && !fill_busy && !ts_pending;
    assign wr_en = pop && !head_cmd.rw;

    // Fill kicks off in the pop cycle so fill_busy is up before the next pop
    assign fill_count = head_cmd.data[gpu_cmd_pkg::FILL_COUNT_W-1:0];
    assign fill_start = wr_en && (head_cmd.addr == gpu_cmd_pkg::REG_FILL_COUNT) &&
                        (fill_count != '0);

    assign ts_req = ts_pending;

    // Frame counter, one step per tick
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            frame_count <= '0;
        end else if (frame_tick) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // ============================================================
    // Register writes
    // ============================================================

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            fill_base    <= '0;
            fill_value   <= '0;
            fill_count_q <= '0;
            ts_wr        <= '0;
            ts_pending   <= 1'b0;
        end else begin
            // Arbiter finished the timestamp write
            if (ts_done) begin
                ts_pending <= 1'b0;
            end
            if (wr_en) begin
                case (head_cmd.addr)
                    gpu_cmd_pkg::REG_FILL_BASE:
                        fill_base <= head_cmd.data[gpu_cmd_pkg::MEM_ADDR_W-1:0];
                    gpu_cmd_pkg::REG_FILL_VALUE:
                        fill_value <= head_cmd.data[gpu_cmd_pkg::MEM_DATA_W-1:0];
                    gpu_cmd_pkg::REG_FILL_COUNT:
                        fill_count_q <= fill_count;
                    gpu_cmd_pkg::REG_TS_ADDR: begin
                        // Snapshot of the frame count at pop time
                        ts_wr.addr  <= head_cmd.data[gpu_cmd_pkg::MEM_ADDR_W-1:0];
                        ts_wr.wdata <= gpu_cmd_pkg::mem_data_t'(frame_count);
                        ts_pending  <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ============================================================
    // Read path
    // ============================================================

    // Unmapped addresses read as zero
    always_comb begin
        case (head_cmd.addr)
            gpu_cmd_pkg::REG_FILL_BASE:   rd_data = gpu_cmd_pkg::reg_data_t'(fill_base);
            gpu_cmd_pkg::REG_FILL_VALUE:  rd_data = gpu_cmd_pkg::reg_data_t'(fill_value);
            gpu_cmd_pkg::REG_FILL_COUNT:  rd_data = gpu_cmd_pkg::reg_data_t'(fill_count_q);
            gpu_cmd_pkg::REG_TS_ADDR:     rd_data = gpu_cmd_pkg::reg_data_t'(ts_wr.addr);
            gpu_cmd_pkg::REG_FRAME_COUNT: rd_data = gpu_cmd_pkg::reg_data_t'(frame_count);
            default:                      rd_data = '0;
        endcase
    end

    // Response one cycle after the read pop
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= pop && head_cmd.rw;
        end
    end

    always_ff @(posedge clk_core) begin
        if (pop && head_cmd.rw) begin
            rsp_data <= rd_data;
        end
    end

endmodule

// ==== logic/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk_core,
    input  logic              rst_n_core,
    input  logic              push,
    input  gpu_cmd_pkg::cmd_t push_cmd,
    input  logic              pop,
    output gpu_cmd_pkg::cmd_t head_cmd,
    output logic              not_empty,
    output logic              cmd_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Entry storage
    gpu_cmd_pkg::cmd_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head is read straight out of the array
    assign head_cmd  = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Sender holds a credit for every push, so no full check
    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            // Pointers wrap at the depth, not at a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per entry freed
            cmd_credit <= pop;
        end
    end

endmodule

// ==== logic/gpu_cmd_pkg.sv ====
package gpu_cmd_pkg;

    // ============================================================
    // Field widths
    // ============================================================

    localparam int REG_ADDR_W    = 7;
    localparam int REG_DATA_W    = 32;
    // Half-word addressing on the memory side
    localparam int MEM_ADDR_W    = 24;
    localparam int MEM_DATA_W    = 16;
    localparam int FRAME_COUNT_W = 16;
    // Word count field of the fill command
    localparam int FILL_COUNT_W  = 20;

    typedef logic [REG_ADDR_W-1:0]    reg_addr_t;
    typedef logic [REG_DATA_W-1:0]    reg_data_t;
    typedef logic [MEM_ADDR_W-1:0]    mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]    mem_data_t;
    typedef logic [FRAME_COUNT_W-1:0] frame_count_t;

    // ============================================================
    // Register map
    // ============================================================

    // Fill start address, low 24 bits
    localparam reg_addr_t REG_FILL_BASE   = 7'h10;
    // Fill pattern, low 16 bits
    localparam reg_addr_t REG_FILL_VALUE  = 7'h11;
    // Word count, nonzero write kicks off a fill
    localparam reg_addr_t REG_FILL_COUNT  = 7'h12;
    // Timestamp target, write queues one memory write
    localparam reg_addr_t REG_TS_ADDR     = 7'h20;
    // Read only frame counter
    localparam reg_addr_t REG_FRAME_COUNT = 7'h30;

    // ============================================================
    // Bundles
    // ============================================================

    // Register command, rw set means read
    typedef struct packed {
        logic      rw;
        reg_addr_t addr;
        reg_data_t data;
    } cmd_t;

    // Single-word memory write
    typedef struct packed {
        mem_addr_t addr;
        mem_data_t wdata;
    } mem_wr_t;

endpackage
